// ==== Makefile ====
# Verilator lint and simulation of the nes host glue
VERILATOR ?= verilator
TB_TOP    ?= nes_host_tb
RTL_TOP   ?= nes_host_top
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/100ps
PASS_TEXT ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

# the run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/nes_host_consts.svh ====
// register numbers on the host command bus and the cycle-enable layout
// include wherever these numbers are decoded or checked

`ifndef NES_HOST_CONSTS_SVH
`define NES_HOST_CONSTS_SVH

// loader and console control
`define REG_LOADER_CONF 8'h35  // bit 0 holds the loader in reset
`define REG_NES_CONFIG  8'h36  // bit 0 selects 8:7 aspect
`define REG_LOADER_DATA 8'h37  // one game byte per write

// controller buttons
`define REG_BUTTONS_1   8'h40
`define REG_BUTTONS_2   8'h41

// on-screen display
`define REG_OSD_ADDR_LO 8'h80  // address bits 7:0
`define REG_OSD_ADDR_HI 8'h81  // address bits 11:8 in the low nibble
`define REG_OSD_DATA    8'h82  // write and advance the address
`define REG_OSD_ENABLE  8'h83  // bit 0 shows the overlay

// sequencer layout
`define CE_PHASES       6
`define MEM_SLOT_PHASE  0      // memory runs here
`define NES_SLOT_PHASE  5      // console runs here

`endif

// ==== common/nes_host_pkg.sv ====
// shared types for the nes host glue
// imported by every block that carries bytes, addresses or the sequencer phase

`default_nettype none

package nes_host_pkg;

  typedef logic [7:0] byte_t;       // command, loader and memory data
  typedef logic [7:0] reg_addr_t;   // register number on the command bus
  typedef logic [21:0] mem_addr_t;  // 4 MB game space
  typedef logic [11:0] osd_addr_t;  // osd character cell
  typedef logic [7:0] buttons_t;    // one controller, bit 0 goes out first

  // six system clocks per console cycle
  typedef enum logic [2:0] {
    phase_0 = 3'd0,  // memory slot
    phase_1 = 3'd1,
    phase_2 = 3'd2,
    phase_3 = 3'd3,
    phase_4 = 3'd4,
    phase_5 = 3'd5   // console slot
  } ce_phase_t;

endpackage

`default_nettype wire

// ==== common/osd_if.sv ====
// on-screen-display write port, from the register block to the display side
// osd_we is a single-cycle strobe with osd_din and osd_addr valid alongside

`timescale 1ns/100ps
`default_nettype none

interface osd_if;
  import nes_host_pkg::*;

  logic      osd_enable;  // overlay shown
  osd_addr_t osd_addr;
  logic      osd_we;      // no back-pressure
  byte_t     osd_din;

  modport source (output osd_enable, output osd_addr, output osd_we, output osd_din);

  modport sink (input osd_enable, input osd_addr, input osd_we, input osd_din);

endinterface

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/nes_host_pkg.sv
common/osd_if.sv
src/host_registers.sv
src/joypad_ports.sv
src/cycle_sequencer.sv
src/memory_request_mux.sv
src/nes_host_top.sv
tb/nes_host_tb.sv

// ==== src/cycle_sequencer.sv ====
// six-phase cycle-enable sequencer that paces memory and console
// console stays in reset until the loader reports done

`timescale 1ns/100ps
`default_nettype none

`include "nes_host_consts.svh"

module cycle_sequencer (
  input  wire  clk,
  input  wire  reset,
  input  wire  loader_done,
  output logic nes_reset,
  output logic run_mem,
  output logic run_nes
);
  import nes_host_pkg::*;

  // phase   0       1       2       3       4       5
  // memory  issue   ....... read in flight ......   data back
  // console                                         run_nes
  ce_phase_t phase;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phase_0;
    end else if (phase == ce_phase_t'(`CE_PHASES - 1)) begin
      phase <= phase_0;  // wrap
    end else begin
      phase <= ce_phase_t'(phase + 3'd1);
    end
  end

  assign nes_reset = ~loader_done;  // held until the game is in memory

  // slot enables, both quiet while the console is held
  assign run_mem = (phase == ce_phase_t'(`MEM_SLOT_PHASE)) && !nes_reset;
  assign run_nes = (phase == ce_phase_t'(`NES_SLOT_PHASE)) && !nes_reset;

endmodule

`default_nettype wire

// ==== src/host_registers.sv ====
// decodes host command writes into loader, console, button and osd state
// every write lands on the next edge; strobes last one cycle

`timescale 1ns/100ps
`default_nettype none

`include "nes_host_consts.svh"

module host_registers (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       cmd_write,
  input  wire nes_host_pkg::reg_addr_t cmd_addr,
  input  wire nes_host_pkg::byte_t  cmd_data,
  output logic                      loader_reset,
  output logic                      aspect_8x7,
  output nes_host_pkg::buttons_t    buttons_1,
  output nes_host_pkg::buttons_t    buttons_2,
  output nes_host_pkg::byte_t       loader_byte,
  output logic                      loader_byte_valid,
  osd_if.source                     osd
);
  import nes_host_pkg::*;

  osd_addr_t addr_cnt;  // next osd cell

  always_ff @(posedge clk) begin
    if (reset) begin
      loader_reset      <= 1'b0;
      aspect_8x7        <= 1'b0;
      buttons_1         <= '0;
      buttons_2         <= '0;
      loader_byte_valid <= 1'b0;
      osd.osd_we        <= 1'b0;
      osd.osd_enable    <= 1'b0;
      addr_cnt          <= '0;
    end else begin
      loader_byte_valid <= 1'b0;
      osd.osd_we        <= 1'b0;
      if (cmd_write) begin
        case (cmd_addr)
          `REG_LOADER_CONF: loader_reset <= cmd_data[0];
          `REG_NES_CONFIG:  aspect_8x7 <= cmd_data[0];
          `REG_LOADER_DATA: loader_byte_valid <= 1'b1;
          `REG_BUTTONS_1:   buttons_1 <= cmd_data;
          `REG_BUTTONS_2:   buttons_2 <= cmd_data;
          `REG_OSD_ADDR_LO: addr_cnt[7:0] <= cmd_data;
          `REG_OSD_ADDR_HI: addr_cnt[11:8] <= cmd_data[3:0];  // upper nibble ignored
          `REG_OSD_DATA: begin
            osd.osd_we <= 1'b1;
            addr_cnt   <= addr_cnt + osd_addr_t'(1);  // auto-increment per byte
          end
          `REG_OSD_ENABLE:  osd.osd_enable <= cmd_data[0];
          default: ;  // unknown numbers are dropped
        endcase
      end
    end
  end

  // data bytes, valid only with their strobes
  always_ff @(posedge clk) begin
    if (cmd_write && cmd_addr == `REG_LOADER_DATA) begin
      loader_byte <= cmd_data;
    end
    if (cmd_write && cmd_addr == `REG_OSD_DATA) begin
      osd.osd_din <= cmd_data;
    end
  end

  // during the strobe the counter has already moved on, so step back one cell
  assign osd.osd_addr = osd.osd_we ? addr_cnt - osd_addr_t'(1) : addr_cnt;

endmodule

`default_nettype wire

// ==== src/joypad_ports.sv ====
// two controller shift registers as the console sees them
// strobe loads both, falling edge of each port clock shifts that port

`timescale 1ns/100ps
`default_nettype none

module joypad_ports (
  input  wire                       clk,
  input  wire                       reset,
  input  wire nes_host_pkg::buttons_t buttons_1,
  input  wire nes_host_pkg::buttons_t buttons_2,
  input  wire                       joypad_strobe,
  input  wire [1:0]                 joypad_clock,
  output logic [1:0]                joypad_data
);
  import nes_host_pkg::*;

  logic [1:0] last_clock;   // previous sample per port
  logic [1:0] clock_fall;
  buttons_t   load_value [2];
  buttons_t   shift_reg [2];

  assign load_value[0] = buttons_1;
  assign load_value[1] = buttons_2;

  assign clock_fall = last_clock & ~joypad_clock;  // high then low

  always_ff @(posedge clk) begin
    if (reset) begin
      last_clock <= 2'b00;
      for (int n = 0; n < 2; n++) begin
        shift_reg[n] <= '0;
      end
    end else begin
      last_clock <= joypad_clock;
      for (int n = 0; n < 2; n++) begin
        if (joypad_strobe) begin
          shift_reg[n] <= load_value[n];  // latch wins over a shift
        end else if (clock_fall[n]) begin
          shift_reg[n] <= {1'b0, shift_reg[n][7:1]};  // zeros after the last button
        end
      end
    end
  end

  // serial bit back to the console
  assign joypad_data = {shift_reg[1][0], shift_reg[0][0]};

endmodule

`default_nettype wire

// ==== src/memory_request_mux.sv ====
// merges loader writes and console requests into one memory request
// purely combinational; also decides when the memory gets a refresh

`timescale 1ns/100ps
`default_nettype none

module memory_request_mux (
  input  wire                        nes_reset,
  input  wire                        run_mem,
  // console side
  input  wire                        cpu_read,
  input  wire                        ppu_read,
  input  wire                        nes_write,
  input  wire nes_host_pkg::mem_addr_t nes_addr,
  input  wire nes_host_pkg::byte_t   nes_dout,
  // loader side
  input  wire                        loader_write,
  input  wire nes_host_pkg::mem_addr_t loader_addr,
  input  wire nes_host_pkg::byte_t   loader_data,
  input  wire                        loader_refresh,
  // memory side
  output logic                       mem_read_a,
  output logic                       mem_read_b,
  output logic                       mem_write,
  output logic                       mem_refresh,
  output nes_host_pkg::mem_addr_t    mem_addr,
  output nes_host_pkg::byte_t        mem_din
);

  logic console_req;  // anything pending from the console

  assign console_req = cpu_read | ppu_read | nes_write;

  // console traffic only goes out in the memory slot
  assign mem_read_a = cpu_read & run_mem;
  assign mem_read_b = ppu_read & run_mem;
  assign mem_write  = (nes_write & run_mem) | loader_write;

  // loader owns the bus whenever it writes
  assign mem_addr = loader_write ? loader_addr : nes_addr;
  assign mem_din  = loader_write ? loader_data : nes_dout;

  // loader paces refresh while loading, then idle memory slots take over
  assign mem_refresh = nes_reset ? loader_refresh : (run_mem & ~console_req);

endmodule

`default_nettype wire

// ==== src/nes_host_top.sv ====
// top level of the nes host glue
// command bus in, register state, joypad serial ports, cycle enables and
// the merged memory request out; console and loader live outside

`timescale 1ns/100ps
`default_nettype none

module nes_host_top (
  input  wire                          clk,
  input  wire                          reset,
  // host command bus
  input  wire                          cmd_write,
  input  wire nes_host_pkg::reg_addr_t cmd_addr,
  input  wire nes_host_pkg::byte_t     cmd_data,
  // loader status and console controller lines
  input  wire                          loader_done,
  input  wire                          joypad_strobe,
  input  wire [1:0]                    joypad_clock,
  output logic [1:0]                   joypad_data,
  // console memory requests
  input  wire                          cpu_read,
  input  wire                          ppu_read,
  input  wire                          nes_write,
  input  wire nes_host_pkg::mem_addr_t nes_addr,
  input  wire nes_host_pkg::byte_t     nes_dout,
  // loader memory requests
  input  wire                          loader_write,
  input  wire nes_host_pkg::mem_addr_t loader_addr,
  input  wire nes_host_pkg::byte_t     loader_data,
  input  wire                          loader_refresh,
  // merged memory request
  output logic                         mem_read_a,
  output logic                         mem_read_b,
  output logic                         mem_write,
  output logic                         mem_refresh,
  output nes_host_pkg::mem_addr_t      mem_addr,
  output nes_host_pkg::byte_t          mem_din,
  // loader and console configuration
  output logic                         loader_reset,
  output logic                         aspect_8x7,
  output nes_host_pkg::byte_t          loader_byte,
  output logic                         loader_byte_valid,
  // on-screen display
  output logic                         osd_enable,
  output nes_host_pkg::osd_addr_t      osd_addr,
  output logic                         osd_we,
  output nes_host_pkg::byte_t          osd_din,
  // console pacing
  output logic                         nes_reset,
  output logic                         run_nes
);
  import nes_host_pkg::*;

  buttons_t buttons_1;
  buttons_t buttons_2;
  logic     run_mem;   // memory slot enable

  osd_if osd_bus ();

  host_registers host_registers_inst (
    .clk               (clk),
    .reset             (reset),
    .cmd_write         (cmd_write),
    .cmd_addr          (cmd_addr),
    .cmd_data          (cmd_data),
    .loader_reset      (loader_reset),
    .aspect_8x7        (aspect_8x7),
    .buttons_1         (buttons_1),
    .buttons_2         (buttons_2),
    .loader_byte       (loader_byte),
    .loader_byte_valid (loader_byte_valid),
    .osd               (osd_bus.source)
  );

  // osd port out to the display side
  assign osd_enable = osd_bus.osd_enable;
  assign osd_addr   = osd_bus.osd_addr;
  assign osd_we     = osd_bus.osd_we;
  assign osd_din    = osd_bus.osd_din;

  joypad_ports joypad_ports_inst (
    .clk           (clk),
    .reset         (reset),
    .buttons_1     (buttons_1),
    .buttons_2     (buttons_2),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

  cycle_sequencer cycle_sequencer_inst (
    .clk         (clk),
    .reset       (reset),
    .loader_done (loader_done),
    .nes_reset   (nes_reset),
    .run_mem     (run_mem),
    .run_nes     (run_nes)
  );

  memory_request_mux memory_request_mux_inst (
    .nes_reset      (nes_reset),
    .run_mem        (run_mem),
    .cpu_read       (cpu_read),
    .ppu_read       (ppu_read),
    .nes_write      (nes_write),
    .nes_addr       (nes_addr),
    .nes_dout       (nes_dout),
    .loader_write   (loader_write),
    .loader_addr    (loader_addr),
    .loader_data    (loader_data),
    .loader_refresh (loader_refresh),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_din        (mem_din)
  );

endmodule

`default_nettype wire

// ==== tb/nes_host_tb.sv ====
// testbench for the nes host glue
// replays tb/nes_host_testdata.txt against the top level and checks the outputs
// against file values or models of the register, joypad and slot rules

`timescale 1ns/100ps
`default_nettype none

`include "nes_host_consts.svh"

module nes_host_tb;
  import nes_host_pkg::*;

  logic clk;
  logic reset;
  logic cmd_write;
  reg_addr_t cmd_addr;
  byte_t cmd_data;
  logic loader_done;
  logic joypad_strobe;
  logic [1:0] joypad_clock;
  logic [1:0] joypad_data;
  logic cpu_read;
  logic ppu_read;
  logic nes_write;
  mem_addr_t nes_addr;
  byte_t nes_dout;
  logic loader_write;
  mem_addr_t loader_addr;
  byte_t loader_data;
  logic loader_refresh;
  logic mem_read_a;
  logic mem_read_b;
  logic mem_write;
  logic mem_refresh;
  mem_addr_t mem_addr;
  byte_t mem_din;
  logic loader_reset;
  logic aspect_8x7;
  byte_t loader_byte;
  logic loader_byte_valid;
  logic osd_enable;
  osd_addr_t osd_addr;
  logic osd_we;
  byte_t osd_din;
  logic nes_reset;
  logic run_nes;

  // records from the data file
  string rec_name[$];
  string rec_kind[$];
  logic [31:0] rec_f1[$];
  logic [31:0] rec_f2[$];
  logic [31:0] rec_f3[$];
  logic [31:0] rec_f4[$];
  logic [31:0] rec_f5[$];

  osd_addr_t osd_addr_model;
  buttons_t button_model [2];
  buttons_t shift_model [2];
  int unsigned cycles_out_of_reset;  // phase reference
  int watchdog_cycles;

  nes_host_top nes_host_top_inst (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (reset) begin
      cycles_out_of_reset <= 0;
    end else begin
      cycles_out_of_reset <= cycles_out_of_reset + 1;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #0.5;
  endtask

  task automatic report_mismatch(input string test, input string signal,
                                 input string expected, input string actual);
    $display("Fail %s: %s expected %s actual %s", test, signal, expected, actual);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_flag(input string test, input string signal,
                            input logic expected, input logic actual);
    if (actual !== expected) begin
      report_mismatch(test, signal, $sformatf("%b", expected), $sformatf("%b", actual));
    end
  endtask

  task automatic check_byte(input string test, input string signal,
                            input byte_t expected, input byte_t actual);
    if (actual !== expected) begin
      report_mismatch(test, signal, $sformatf("%h", expected), $sformatf("%h", actual));
    end
  endtask

  task automatic check_joypad(input string test, input logic [1:0] expected,
                              input logic [1:0] actual);
    if (actual !== expected) begin
      report_mismatch(test, "joypad_data", $sformatf("%b", expected), $sformatf("%b", actual));
    end
  endtask

  task automatic check_mem_addr(input string test, input mem_addr_t expected,
                                input mem_addr_t actual);
    if (actual !== expected) begin
      report_mismatch(test, "mem_addr", $sformatf("%h", expected), $sformatf("%h", actual));
    end
  endtask

  task automatic check_osd_addr(input string test, input osd_addr_t expected,
                                input osd_addr_t actual);
    if (actual !== expected) begin
      report_mismatch(test, "osd_addr", $sformatf("%h", expected), $sformatf("%h", actual));
    end
  endtask

  // slot enable expected from the cycle count since reset
  function automatic logic slot_active(input int unsigned phase_no);
    return loader_done && ((cycles_out_of_reset % `CE_PHASES) == phase_no);
  endfunction

  task automatic load_records();
    int fd;
    int code;
    string name;
    string kind;
    string rest;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
    fd = $fopen("tb/nes_host_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/nes_host_testdata.txt");
      $display("ERRORS FOUND");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) break;
      if (name.getc(0) == "#") begin
        code = $fgets(rest, fd);  // skip the comment text
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h %h", kind, f1, f2, f3, f4, f5);
        if (code != 6) begin
          $display("record %s in the data file is incomplete", name);
          $display("ERRORS FOUND");
          $fatal(1);
        end
        rec_name.push_back(name);
        rec_kind.push_back(kind);
        rec_f1.push_back(f1);
        rec_f2.push_back(f2);
        rec_f3.push_back(f3);
        rec_f4.push_back(f4);
        rec_f5.push_back(f5);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input string test, input reg_addr_t addr, input byte_t data,
                             input logic [2:0] flags);
    next_cycle();
    cmd_write = 1'b1;
    cmd_addr  = addr;
    cmd_data  = data;
    next_cycle();
    cmd_write = 1'b0;
    #1;
    check_flag(test, "loader_reset", flags[0], loader_reset);
    check_flag(test, "aspect_8x7", flags[1], aspect_8x7);
    check_flag(test, "osd_enable", flags[2], osd_enable);
    check_flag(test, "loader_byte_valid", addr == `REG_LOADER_DATA, loader_byte_valid);
    check_flag(test, "osd_we", addr == `REG_OSD_DATA, osd_we);
    case (addr)
      `REG_LOADER_DATA: check_byte(test, "loader_byte", data, loader_byte);
      `REG_BUTTONS_1:   button_model[0] = data;
      `REG_BUTTONS_2:   button_model[1] = data;
      `REG_OSD_ADDR_LO: osd_addr_model[7:0] = data;
      `REG_OSD_ADDR_HI: osd_addr_model[11:8] = data[3:0];
      `REG_OSD_DATA: begin
        check_byte(test, "osd_din", data, osd_din);
        check_osd_addr(test, osd_addr_model, osd_addr);  // address before the step
        osd_addr_model = osd_addr_model + osd_addr_t'(1);
      end
      default: ;
    endcase
    // strobes must be gone one cycle later
    next_cycle();
    #1;
    check_flag(test, "loader_byte_valid", 1'b0, loader_byte_valid);
    check_flag(test, "osd_we", 1'b0, osd_we);
    check_osd_addr(test, osd_addr_model, osd_addr);
  endtask

  task automatic run_joypad(input string test, input logic action, input logic [1:0] mask,
                            input int pulses);
    if (!action) begin
      next_cycle();
      joypad_strobe = 1'b1;
      next_cycle();
      joypad_strobe = 1'b0;
      #1;
      shift_model[0] = button_model[0];
      shift_model[1] = button_model[1];
      check_joypad(test, {shift_model[1][0], shift_model[0][0]}, joypad_data);
    end else begin
      repeat (pulses) begin
        next_cycle();
        joypad_clock = mask;
        next_cycle();
        joypad_clock = 2'b00;  // falling edge on the masked ports
        next_cycle();
        #1;
        for (int n = 0; n < 2; n++) begin
          if (mask[n]) shift_model[n] = shift_model[n] >> 1;
        end
        check_joypad(test, {shift_model[1][0], shift_model[0][0]}, joypad_data);
      end
    end
  endtask

  task automatic run_sequence(input string test, input logic done, input int cycles);
    next_cycle();
    loader_done = done;
    repeat (cycles) begin
      #1;
      check_flag(test, "nes_reset", !loader_done, nes_reset);
      check_flag(test, "run_nes", slot_active(`NES_SLOT_PHASE), run_nes);
      next_cycle();
    end
  endtask

  task automatic run_memory(input string test, input logic [1:0] flags, input mem_addr_t laddr,
                            input mem_addr_t naddr, input logic [15:0] data, input int cycles);
    logic [2:0] req;  // cpu_read, ppu_read, nes_write
    logic slot;
    repeat (cycles) begin
      next_cycle();
      req = 3'($urandom);
      cpu_read       = req[0];
      ppu_read       = req[1];
      nes_write      = req[2];
      loader_write   = flags[0];
      loader_refresh = flags[1];
      loader_addr    = laddr;
      nes_addr       = naddr;
      loader_data    = data[15:8];
      nes_dout       = data[7:0];
      #1;
      slot = slot_active(`MEM_SLOT_PHASE);
      check_flag(test, "mem_read_a", req[0] & slot, mem_read_a);
      check_flag(test, "mem_read_b", req[1] & slot, mem_read_b);
      check_flag(test, "mem_write", (req[2] & slot) | flags[0], mem_write);
      check_mem_addr(test, flags[0] ? laddr : naddr, mem_addr);
      check_byte(test, "mem_din", flags[0] ? data[15:8] : data[7:0], mem_din);
      check_flag(test, "mem_refresh", loader_done ? (slot & (req == 3'b000)) : flags[1],
                 mem_refresh);
    end
  endtask

  initial begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial begin
    void'($urandom(59396));
    reset          = 1'b1;
    cmd_write      = 1'b0;
    cmd_addr       = '0;
    cmd_data       = '0;
    loader_done    = 1'b0;
    joypad_strobe  = 1'b0;
    joypad_clock   = 2'b00;
    cpu_read       = 1'b0;
    ppu_read       = 1'b0;
    nes_write      = 1'b0;
    nes_addr       = '0;
    nes_dout       = '0;
    loader_write   = 1'b0;
    loader_addr    = '0;
    loader_data    = '0;
    loader_refresh = 1'b0;
    osd_addr_model = '0;
    button_model   = '{default: '0};
    shift_model    = '{default: '0};
    load_records();
    if (rec_name.size() == 0) begin
      $display("the data file holds no test records");
      $display("ERRORS FOUND");
      $fatal(1);
    end
    watchdog_cycles = rec_name.size() * 40;
    repeat (3) next_cycle();
    reset = 1'b0;
    #1;
    check_flag("reset_values", "loader_reset", 1'b0, loader_reset);
    check_flag("reset_values", "aspect_8x7", 1'b0, aspect_8x7);
    check_flag("reset_values", "osd_enable", 1'b0, osd_enable);
    check_flag("reset_values", "loader_byte_valid", 1'b0, loader_byte_valid);
    check_flag("reset_values", "osd_we", 1'b0, osd_we);
    check_osd_addr("reset_values", osd_addr_model, osd_addr);
    check_joypad("reset_values", 2'b00, joypad_data);
    for (int i = 0; i < rec_name.size(); i++) begin
      if (rec_kind[i] == "command") begin
        run_command(rec_name[i], reg_addr_t'(rec_f1[i]), byte_t'(rec_f2[i]), 3'(rec_f3[i]));
      end else if (rec_kind[i] == "joypad") begin
        run_joypad(rec_name[i], rec_f1[i][0], 2'(rec_f2[i]), int'(rec_f3[i]));
      end else if (rec_kind[i] == "sequence") begin
        run_sequence(rec_name[i], rec_f1[i][0], int'(rec_f2[i]));
      end else if (rec_kind[i] == "memory") begin
        run_memory(rec_name[i], 2'(rec_f1[i]), mem_addr_t'(rec_f2[i]), mem_addr_t'(rec_f3[i]),
                   16'(rec_f4[i]), int'(rec_f5[i]));
      end else begin
        $display("record %s has an unknown kind %s", rec_name[i], rec_kind[i]);
        $display("ERRORS FOUND");
        $fatal(1);
      end
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/nes_host_testdata.txt ====
# columns: test kind f1 f2 f3 f4 f5, fields in hex, unused fields are 0
# command: f1 register, f2 data, f3 expected {osd_enable, aspect_8x7, loader_reset}
# joypad: f1 action (0 strobe, 1 clock), f2 port mask, f3 falling edges
# sequence: f1 loader_done, f2 cycles; memory: f1 {loader_refresh, loader_write},
# f2 loader_addr, f3 nes_addr, f4 {loader_data, nes_dout}, f5 cycles
loader_reset_on    command  35 01 1 0 0
aspect_on          command  36 01 3 0 0
osd_on             command  83 01 7 0 0
unknown_register   command  50 ff 7 0 0
loader_reset_off   command  35 00 6 0 0
aspect_bit0_only   command  36 fe 4 0 0
loader_byte_a      command  37 a5 4 0 0
loader_byte_b      command  37 3c 4 0 0
osd_addr_low       command  80 fe 4 0 0
osd_addr_high      command  81 f1 4 0 0
osd_data_0         command  82 41 4 0 0
osd_data_1         command  82 42 4 0 0
osd_data_2         command  82 43 4 0 0
osd_data_3         command  82 44 4 0 0
osd_off            command  83 00 0 0 0
buttons_port0      command  40 b5 0 0 0
buttons_port1      command  41 4e 0 0 0
joypad_load        joypad   0 0 0 0 0
joypad_port0       joypad   1 1 3 0 0
joypad_port1       joypad   1 2 2 0 0
joypad_both_out    joypad   1 3 6 0 0
joypad_reload      joypad   0 0 0 0 0
joypad_reload_both joypad   1 3 2 0 0
console_held       sequence 0 c 0 0 0
mem_load_refresh   memory   2 000000 155555 0000 6
mem_load_write     memory   1 012345 3abcde 5aa5 6
mem_load_idle      memory   0 000000 2aaaaa 00ff 4
console_running    sequence 1 18 0 0 0
mem_run_console    memory   0 000100 2f0f0f 1234 c
mem_run_loader     memory   1 001000 200000 c33c c
mem_run_no_loader  memory   2 000000 000100 0011 c
console_held_again sequence 0 6 0 0 0
mem_held_refresh   memory   2 3fffff 3ffffe 8001 6
